// ==== common/dispatchPkg.sv ====
// shared definitions for the two-wide dispatch stage
// holds the opcode encoding, the instruction word layout and the field helpers
// every RTL file refers to these by scoped name through dispatchPkg::

package dispatchPkg;

	// ==============================
	// instruction word layout
	// ==============================

	// a word is opcode in the top bits, then the predicted-taken flag, then the tag
	localparam int opWidth = 3;
	localparam int tagWidth = 8;
	localparam int instrWidth = opWidth + 1 + tagWidth;

	// opcodes seen by dispatch
	// only the control-flow ones change how a group is formed
	typedef enum logic [opWidth-1:0] {
		opAlu    = 3'd0,
		opLoad   = 3'd1,
		opStore  = 3'd2,
		opBranch = 3'd3,
		opJmp    = 3'd4,
		opBrk    = 3'd5
	} opcodeT;

	// ==============================
	// field helpers
	// ==============================

	// pull the opcode field out of a word
	function automatic opcodeT instrOpcode(input logic [instrWidth-1:0] word);
		return opcodeT'(word[instrWidth-1 -: opWidth]);
	endfunction

	// the predicted-taken flag sits just above the tag
	function automatic logic instrTaken(input logic [instrWidth-1:0] word);
		return word[tagWidth];
	endfunction

	// true when this word has to be the last one of its dispatch group
	// jumps and breaks always end a group, branches only when predicted taken
	function automatic logic slotBlocks(input logic [instrWidth-1:0] word);
		logic blocks;
		blocks = 1'b0;
		case (instrOpcode(word))
			opJmp: blocks = 1'b1;
			opBrk: blocks = 1'b1;
			opBranch: blocks = instrTaken(word);
			default: blocks = 1'b0;
		endcase
		return blocks;
	endfunction

endpackage

// ==== hdl/fetchBuffer.sv ====
// input side of dispatch
// accepts one word per four-phase req/ack cycle into a two-slot decode buffer
// slots flagged by the count block leave, and slot 1 moves down into slot 0

`timescale 1ns/1ps

module fetchBuffer (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               branchMiss,
	input  logic                               inReq,
	input  logic [dispatchPkg::instrWidth-1:0] inInstr,
	output logic                               inAck,
	input  logic [1:0]                         queuedOn,
	output logic                               slotValid0,
	output logic                               slotValid1,
	output logic [dispatchPkg::instrWidth-1:0] slotInstr0,
	output logic [dispatchPkg::instrWidth-1:0] slotInstr1
);

	typedef enum logic [1:0] {fbIdle, fbAck, fbWaitDrop} fbStateT;

	fbStateT state;
	logic capture;
	logic keep0V;
	logic keep1V;
	logic [dispatchPkg::instrWidth-1:0] keep0I;

	// ==============================
	// four-phase handshake
	// ==============================

	// a word is taken only when slot 1 is empty, since slots fill in order
	assign capture = (state == fbIdle) && inReq && !slotValid1 && !branchMiss;

	// ack is high for the whole time between capture and the drop of req
	assign inAck = (state != fbIdle);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fbIdle;
		end else begin
			case (state)
				fbIdle: if (capture) state <= fbAck;
				fbAck: state <= inReq ? fbWaitDrop : fbIdle;
				fbWaitDrop: if (!inReq) state <= fbIdle;
				default: state <= fbIdle;
			endcase
		end
	end

	// ==============================
	// decode slots
	// ==============================

	// work out what is left once the queued slots have gone
	// when slot 0 leaves, whatever stays in slot 1 shifts down
	always_comb begin
		keep0V = slotValid0;
		keep0I = slotInstr0;
		keep1V = slotValid1 && !queuedOn[1];
		if (queuedOn[0]) begin
			keep0V = slotValid1 && !queuedOn[1];
			keep0I = slotInstr1;
			keep1V = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || branchMiss) begin
			slotValid0 <= 1'b0;
			slotValid1 <= 1'b0;
		end else begin
			slotValid0 <= keep0V || capture;
			slotValid1 <= keep1V || (capture && keep0V);
		end
	end

	// a new word goes into the lowest slot that is empty after the shift
	always_ff @(posedge clk) begin
		slotInstr0 <= (capture && !keep0V) ? inInstr : keep0I;
		if (capture && keep0V)
			slotInstr1 <= inInstr;
	end

	// ack may only come up after a cycle in which req was seen high
	ackFollowsReq: assert property (@(posedge clk) disable iff (rst)
		$rose(inAck) |-> $past(inReq));

endmodule

// ==== hdl/queuedCount.sv ====
// decides each cycle how many decode slots move into the issue queue
// the combinational flags go to the allocator, the registered copy goes back
// to the decode buffer one cycle later so it can drop the queued slots

`timescale 1ns/1ps

module queuedCount (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               branchMiss,
	input  logic                               slotValid0,
	input  logic                               slotValid1,
	input  logic [dispatchPkg::instrWidth-1:0] slotInstr0,
	input  logic                               tailFree,
	output logic [1:0]                         queuedOnp,
	output logic [1:0]                         queuedOn,
	output logic [1:0]                         queuedCnt
);

	logic [1:0] cntNext;
	logic slot0Blocks;

	// ==============================
	// group formation
	// ==============================

	assign slot0Blocks = dispatchPkg::slotBlocks(slotInstr0);

	// nothing moves on a miss or when the two tail entries are not both free
	// the slots queued last cycle are still sitting in the buffer this cycle,
	// so a nonzero queuedOn holds everything back for one cycle
	always_comb begin
		queuedOnp = 2'b00;
		if (!branchMiss && tailFree && (queuedOn == 2'b00)) begin
			queuedOnp[0] = slotValid0;
			// slot 1 joins only if slot 0 does not end the group
			if (slotValid1 && (!slotValid0 || !slot0Blocks))
				queuedOnp[1] = 1'b1;
		end
	end

	assign cntNext = {1'b0, queuedOnp[0]} + {1'b0, queuedOnp[1]};

	// registered copy of the decision for the decode buffer
	always_ff @(posedge clk) begin
		if (rst) begin
			queuedOn <= 2'b00;
			queuedCnt <= 2'd0;
		end else begin
			queuedOn <= queuedOnp;
			queuedCnt <= cntNext;
		end
	end

	// slots fill in order, so slot 1 never goes ahead of a valid slot 0
	slot1AfterSlot0: assert property (@(posedge clk) disable iff (rst)
		(slotValid0 && queuedOnp[1]) |-> queuedOnp[0]);

endmodule

// ==== iq/iqAllocator.sv ====
// tail side of the issue queue
// writes up to two decode slots per cycle into the ring at the tail pointer,
// and reports whether the two entries at the tail are free for the next group

`timescale 1ns/1ps

module iqAllocator #(
	parameter int iqEntries = 8
) (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               branchMiss,
	input  logic [1:0]                         queuedOnp,
	input  logic [dispatchPkg::instrWidth-1:0] slotInstr0,
	input  logic [dispatchPkg::instrWidth-1:0] slotInstr1,
	input  logic [iqEntries-1:0]               entryValid,
	input  logic [$clog2(iqEntries)-1:0]       headPtr,
	output logic                               tailFree,
	output logic [iqEntries-1:0]               wrEn,
	output logic [iqEntries-1:0]               wrSel,
	output logic [dispatchPkg::instrWidth-1:0] wrInstr0,
	output logic [dispatchPkg::instrWidth-1:0] wrInstr1
);

	localparam int ptrW = $clog2(iqEntries);

	logic [ptrW-1:0] tailPtr;
	logic [ptrW-1:0] tailNext;
	logic [1:0] advance;

	// the ring size is a power of two, so the pointers wrap on their own
	assign tailNext = tailPtr + 1'b1;

	// a two-wide group needs both tail entries, even for a single word
	assign tailFree = !entryValid[tailPtr] && !entryValid[tailNext];

	// every entry sees the same pair of words and picks one with wrSel
	assign wrInstr0 = slotInstr0;
	assign wrInstr1 = slotInstr1;

	assign advance = {1'b0, queuedOnp[0]} + {1'b0, queuedOnp[1]};

	// ==============================
	// write enable decode
	// ==============================

	always_comb begin
		wrEn = '0;
		wrSel = '0;
		case (queuedOnp)
			2'b01: wrEn[tailPtr] = 1'b1;
			// slot 1 alone happens only when slot 0 is empty
			2'b10: begin
				wrEn[tailPtr] = 1'b1;
				wrSel[tailPtr] = 1'b1;
			end
			2'b11: begin
				wrEn[tailPtr] = 1'b1;
				wrEn[tailNext] = 1'b1;
				wrSel[tailNext] = 1'b1;
			end
			default: wrEn = '0;
		endcase
	end

	// on a flush every entry is cleared, so the tail falls back to the head
	always_ff @(posedge clk) begin
		if (rst)
			tailPtr <= '0;
		else if (branchMiss)
			tailPtr <= headPtr;
		else
			tailPtr <= tailPtr + ptrW'(advance);
	end

endmodule

// ==== iq/iqEntry.sv ====
// one issue-queue entry
// holds a valid bit and a word, set by the allocator and cleared by the
// issue unit or by a flush

`timescale 1ns/1ps

module iqEntry #(
	parameter int iqEntries = 8
) (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               branchMiss,
	input  logic                               wrEn,
	input  logic                               wrSel,
	input  logic [dispatchPkg::instrWidth-1:0] wrInstr0,
	input  logic [dispatchPkg::instrWidth-1:0] wrInstr1,
	input  logic                               clrEn,
	output logic                               entryValid,
	output logic [dispatchPkg::instrWidth-1:0] entryInstr
);

	// the head and tail pointers index the ring by plain wraparound,
	// which needs a power-of-two ring of at least four entries
	if (iqEntries < 4 || (iqEntries & (iqEntries - 1)) != 0) begin : gSizeCheck
		$error("iqEntries must be a power of two of at least 4");
	end

	// ==============================
	// valid bit
	// ==============================

	// the allocator writes only free entries and the issue unit clears only
	// a valid one, so write and clear never land in the same cycle
	always_ff @(posedge clk) begin
		if (rst || branchMiss)
			entryValid <= 1'b0;
		else if (wrEn)
			entryValid <= 1'b1;
		else if (clrEn)
			entryValid <= 1'b0;
	end

	// ==============================
	// payload
	// ==============================

	// wrSel picks which decode slot this entry takes
	always_ff @(posedge clk) begin
		if (wrEn)
			entryInstr <= wrSel ? wrInstr1 : wrInstr0;
	end

endmodule

// ==== iq/iqIssue.sv ====
// head side of the issue queue
// drains the ring in program order over a four-phase req/ack port and
// clears each entry once the consumer has taken it

`timescale 1ns/1ps

module iqIssue #(
	parameter int iqEntries = 8
) (
	input  logic                                              clk,
	input  logic                                              rst,
	input  logic                                              branchMiss,
	input  logic [iqEntries-1:0]                              entryValid,
	input  logic [iqEntries-1:0][dispatchPkg::instrWidth-1:0] entryInstr,
	input  logic                                              issueAck,
	output logic [iqEntries-1:0]                              clrEn,
	output logic [$clog2(iqEntries)-1:0]                      headPtr,
	output logic                                              issueReq,
	output logic [dispatchPkg::instrWidth-1:0]                issueInstr
);

	typedef enum logic [1:0] {isIdle, isReq, isWaitAckLow} isStateT;

	isStateT state;
	logic headReady;
	logic taken;

	// a request starts only from a valid head and never in a flush cycle
	assign headReady = (state == isIdle) && entryValid[headPtr] && !branchMiss;

	// the consumer has taken the word in the cycle it raises ack
	assign taken = (state == isReq) && issueAck;

	// the head entry is cleared at the same edge that drops the request
	always_comb begin
		clrEn = '0;
		clrEn[headPtr] = taken;
	end

	// ==============================
	// output handshake
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= isIdle;
			issueReq <= 1'b0;
			headPtr <= '0;
		end else begin
			case (state)
				isIdle: begin
					if (headReady) begin
						issueReq <= 1'b1;
						state <= isReq;
					end
				end
				isReq: begin
					if (issueAck) begin
						issueReq <= 1'b0;
						headPtr <= headPtr + 1'b1;
						state <= isWaitAckLow;
					end
				end
				// four-phase return to zero before the next word goes out
				isWaitAckLow: if (!issueAck) state <= isIdle;
				default: state <= isIdle;
			endcase
		end
	end

	// the head word is latched once, when the request goes up
	always_ff @(posedge clk) begin
		if (headReady)
			issueInstr <= entryInstr[headPtr];
	end

	// the consumer may sample the word at any point while req is high
	issueInstrStable: assert property (@(posedge clk) disable iff (rst)
		($past(issueReq) && issueReq) |-> $stable(issueInstr));

endmodule

// ==== hdl/dispatchCore.sv ====
// top level of the two-wide dispatch stage
// connects the decode buffer, the count block, the allocator, the ring of
// issue-queue entries and the issue unit

`timescale 1ns/1ps

module dispatchCore #(
	parameter int iqEntries = 8
) (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               branchMiss,
	input  logic                               inReq,
	input  logic [dispatchPkg::instrWidth-1:0] inInstr,
	output logic                               inAck,
	output logic                               issueReq,
	input  logic                               issueAck,
	output logic [dispatchPkg::instrWidth-1:0] issueInstr
);

	localparam int ptrW = $clog2(iqEntries);

	logic slotValid0;
	logic slotValid1;
	logic [dispatchPkg::instrWidth-1:0] slotInstr0;
	logic [dispatchPkg::instrWidth-1:0] slotInstr1;
	logic [1:0] queuedOnp;
	logic [1:0] queuedOn;
	logic tailFree;
	logic [iqEntries-1:0] wrEn;
	logic [iqEntries-1:0] wrSel;
	logic [dispatchPkg::instrWidth-1:0] wrInstr0;
	logic [dispatchPkg::instrWidth-1:0] wrInstr1;
	logic [iqEntries-1:0] clrEn;
	logic [iqEntries-1:0] entryValid;
	logic [iqEntries-1:0][dispatchPkg::instrWidth-1:0] entryInstr;
	logic [ptrW-1:0] headPtr;

	// ==============================
	// decode side
	// ==============================

	fetchBuffer u_fetchBuffer (
		.clk, .rst, .branchMiss, .inReq, .inInstr, .inAck, .queuedOn,
		.slotValid0, .slotValid1, .slotInstr0, .slotInstr1
	);

	// the registered count is a status output and has no reader here
	queuedCount u_queuedCount (
		.clk, .rst, .branchMiss, .slotValid0, .slotValid1, .slotInstr0,
		.tailFree, .queuedOnp, .queuedOn, .queuedCnt()
	);

	// ==============================
	// issue queue
	// ==============================

	iqAllocator #(.iqEntries(iqEntries)) u_iqAllocator (
		.clk, .rst, .branchMiss, .queuedOnp, .slotInstr0, .slotInstr1, .entryValid,
		.headPtr, .tailFree, .wrEn, .wrSel, .wrInstr0, .wrInstr1
	);

	for (genvar i = 0; i < iqEntries; i++) begin : gEntry
		iqEntry #(.iqEntries(iqEntries)) u_iqEntry (
			.clk, .rst, .branchMiss, .wrEn(wrEn[i]), .wrSel(wrSel[i]), .wrInstr0,
			.wrInstr1, .clrEn(clrEn[i]), .entryValid(entryValid[i]),
			.entryInstr(entryInstr[i])
		);
	end

	iqIssue #(.iqEntries(iqEntries)) u_iqIssue (
		.clk, .rst, .branchMiss, .entryValid, .entryInstr, .issueAck, .clrEn,
		.headPtr, .issueReq, .issueInstr
	);

endmodule

// ==== dv/dispatchModel.svh ====
// reference model for the dispatch testbench
// included inside the testbench module, it keeps every acknowledged word in
// program order until the issue port hands it out or a branch miss drops it

`ifndef dispatchModelSvh
`define dispatchModelSvh

// ==============================
// expected word queue
// ==============================

// words the DUT has acknowledged and not yet issued, oldest at the front
logic [dispatchPkg::instrWidth-1:0] expectedQ[$];

// an acknowledged word joins the back, since dispatch keeps program order
task automatic pushExpected(input logic [dispatchPkg::instrWidth-1:0] word);
	expectedQ.push_back(word);
endtask

// a branch miss empties the decode buffer and the ring at one edge,
// so nothing that was pending may ever come out of the issue port
task automatic flushExpected();
	expectedQ.delete();
endtask

// hands out the oldest pending word
// found stays low when the model holds nothing at all
task automatic popExpected(
	output logic [dispatchPkg::instrWidth-1:0] word,
	output bit found
);
	found = (expectedQ.size() != 0);
	word = '0;
	if (found)
		word = expectedQ.pop_front();
endtask

// number of words still waiting to be issued
function automatic int pendingCount();
	return expectedQ.size();
endfunction

`endif

// ==== dv/tbDispatch.sv ====
// testbench for the two-wide dispatch stage
// drives random words through the four-phase input port, drains the issue
// port with random ack delays and checks every issued word against a model

`timescale 1ns/1ps

module tbDispatch;

	localparam int iqEntries = 8;
	localparam int instrW = dispatchPkg::instrWidth;

	logic clk;
	logic rst;
	logic branchMiss;
	logic inReq;
	logic [instrW-1:0] inInstr;
	logic inAck;
	logic issueReq;
	logic issueAck;
	logic [instrW-1:0] issueInstr;

	logic [31:0] lcgState;
	logic [7:0] tagCount;
	int errors;
	int checks;
	int accepted;
	bit ok;
	bit stale;
	string testName;

	`include "dispatchModel.svh"

	dispatchCore #(.iqEntries(iqEntries)) u_dispatchCore (
		.clk, .rst, .branchMiss, .inReq, .inInstr, .inAck, .issueReq, .issueAck,
		.issueInstr
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ==============================
	// helpers
	// ==============================

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// each word carries a running tag, so a lost or doubled word shows up
	// dense words are mostly jumps, breaks and taken branches that end a group
	function automatic logic [instrW-1:0] makeWord(input bit dense);
		logic [31:0] r;
		dispatchPkg::opcodeT op;
		r = nextRand();
		op = dispatchPkg::opcodeT'(r[26:24] % 3'd6);
		if (dense) begin
			case (r[31:30])
				2'd0: op = dispatchPkg::opJmp;
				2'd1: op = dispatchPkg::opBrk;
				2'd2: op = dispatchPkg::opBranch;
				default: op = dispatchPkg::opAlu;
			endcase
		end
		tagCount = tagCount + 8'd1;
		return {op, dense | r[28], tagCount};
	endfunction

	task automatic compareValues(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("MISMATCH %s %s expected %h actual %h", testName, what, expected, actual);
		end
	endtask

	task automatic reportFailure(input string what);
		errors++;
		$display("ERROR in %s at %0t: %s", testName, $time, what);
	endtask

	// polls on falling edges until the chosen output reaches level
	task automatic waitLevel(input bit onIssue, input logic level, input int limit,
			output bit reached);
		int cycles;
		cycles = 0;
		while ((onIssue ? issueReq : inAck) !== level && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		reached = ((onIssue ? issueReq : inAck) === level);
	endtask

	// one full four-phase cycle on the input port
	// if ack never comes, req is dropped on a falling edge with ack still low,
	// so the word cannot have been captured
	task automatic sendWord(input logic [instrW-1:0] word, input int limit, output bit taken);
		bit dropped;
		@(negedge clk);
		inInstr = word;
		inReq = 1'b1;
		waitLevel(1'b0, 1'b1, limit, taken);
		inReq = 1'b0;
		if (taken) begin
			pushExpected(word);
			waitLevel(1'b0, 1'b0, 20, dropped);
			if (!dropped)
				reportFailure("inAck stayed high after inReq went low");
		end
	endtask

	task automatic sendStream(input int n, input bit dense);
		logic [31:0] r;
		bit taken;
		for (int k = 0; k < n; k++) begin
			r = nextRand();
			repeat (r[31:30]) @(negedge clk);
			sendWord(makeWord(dense), 200, taken);
			if (!taken) begin
				reportFailure("inAck never rose for an offered word");
				return;
			end
		end
	endtask

	// consumer side, with keepAck the last ack is left high
	task automatic drainWords(input int n, input bit keepAck);
		logic [instrW-1:0] expected;
		logic [31:0] r;
		bit found;
		bit seen;
		for (int k = 0; k < n; k++) begin
			waitLevel(1'b1, 1'b1, 400, seen);
			if (!seen) begin
				reportFailure("issueReq never rose while words were pending");
				return;
			end
			popExpected(expected, found);
			if (!found)
				reportFailure("the DUT issued a word that was never accepted");
			compareValues("issued word", expected, issueInstr);
			r = nextRand();
			repeat (r[31:30]) @(negedge clk);
			issueAck = 1'b1;
			waitLevel(1'b1, 1'b0, 20, seen);
			if (!seen)
				reportFailure("issueReq stayed high after issueAck");
			if (!keepAck || k != n - 1)
				issueAck = 1'b0;
		end
	endtask

	// a quiet window on the issue port, nothing may be requested in it
	task automatic watchQuiet(input int cycles, output bit rose);
		rose = 1'b0;
		repeat (cycles) begin
			@(negedge clk);
			if (issueReq)
				rose = 1'b1;
		end
	endtask

	// ==============================
	// test sequence
	// ==============================

	initial begin
		rst = 1'b1;
		branchMiss = 1'b0;
		inReq = 1'b0;
		inInstr = '0;
		issueAck = 1'b0;
		lcgState = 32'hc29a_cbad;
		tagCount = 8'd0;
		errors = 0;
		checks = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		testName = "reset";
		compareValues("inAck", 0, inAck);
		compareValues("issueReq", 0, issueReq);

		testName = "random streams";
		repeat (3) begin
			fork
				sendStream(40, 1'b0);
				drainWords(40, 1'b0);
			join
		end
		watchQuiet(20, stale);
		if (stale)
			reportFailure("issueReq rose with no word pending");
		compareValues("words left", 0, pendingCount());

		testName = "dense control flow";
		fork
			sendStream(60, 1'b1);
			drainWords(60, 1'b0);
		join
		compareValues("words left", 0, pendingCount());

		// with ack held off, the ring may keep one entry empty since a group
		// needs two free tail entries, and the decode buffer holds two more
		testName = "back-pressure";
		accepted = 0;
		ok = 1'b1;
		while (ok && accepted < iqEntries + 4) begin
			sendWord(makeWord(1'b0), 40, ok);
			if (ok)
				accepted++;
		end
		if (accepted < iqEntries || accepted > iqEntries + 2)
			reportFailure($sformatf("inAck stalled after %0d words", accepted));
		drainWords(accepted, 1'b0);
		compareValues("words left", 0, pendingCount());

		// the last ack stays high, so issueReq is low while words wait
		testName = "branch miss";
		sendWord(makeWord(1'b0), 200, ok);
		drainWords(1, 1'b1);
		repeat (3) sendWord(makeWord(1'b0), 200, ok);
		compareValues("words before flush", 3, pendingCount());
		@(negedge clk);
		branchMiss = 1'b1;
		@(negedge clk);
		branchMiss = 1'b0;
		flushExpected();
		issueAck = 1'b0;
		watchQuiet(20, stale);
		if (stale)
			reportFailure("a word accepted before the flush was issued");
		fork
			sendStream(12, 1'b0);
			drainWords(12, 1'b0);
		join
		compareValues("words left", 0, pendingCount());

		$display("checks run %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+dv
common/dispatchPkg.sv
hdl/fetchBuffer.sv
hdl/queuedCount.sv
iq/iqAllocator.sv
iq/iqEntry.sv
iq/iqIssue.sv
hdl/dispatchCore.sv
dv/tbDispatch.sv

// ==== Bender.yml ====
package:
  name: dispatch

sources:
  - common/dispatchPkg.sv
  - hdl/fetchBuffer.sv
  - hdl/queuedCount.sv
  - iq/iqAllocator.sv
  - iq/iqEntry.sv
  - iq/iqIssue.sv
  - hdl/dispatchCore.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tbDispatch.sv
